/* Bender.yml */
package:
  name: concat_stage

sources:
  - files:
      - verilog/concat_pkg.sv
      - verilog/quant_pkg.sv
      - verilog/stream_fifo.sv
      - verilog/concat_requant.sv
      - verilog/concat_sequencer.sv
      - verilog/concat_tracker.sv
      - verilog/concat_top.sv
  - target: test
    files:
      - tests/tb_concat_checker.sv
      - tests/tb_concat_top.sv

/* sources.f */
verilog/concat_pkg.sv
verilog/quant_pkg.sv
verilog/stream_fifo.sv
verilog/concat_requant.sv
verilog/concat_sequencer.sv
verilog/concat_tracker.sv
verilog/concat_top.sv
tests/tb_concat_checker.sv
tests/tb_concat_top.sv

/* tests/tb_concat_checker.sv */
`timescale 1ns/1ps

module tb_concat_checker (
    input  logic                clk,
    input  logic                rst,
    input  concat_pkg::dim_t    rows,
    input  concat_pkg::dim_t    cols,
    input  concat_pkg::chan_t   first_channels,
    input  concat_pkg::chan_t   second_channels,
    input  quant_pkg::zero_t    first_zero,
    input  quant_pkg::scale_t   first_scale,
    input  quant_pkg::zero_t    second_zero,
    input  quant_pkg::scale_t   second_scale,
    input  concat_pkg::beat_t   s1_data,
    input  logic                s1_valid,
    input  logic                s1_ready,
    input  concat_pkg::beat_t   s2_data,
    input  logic                s2_valid,
    input  logic                s2_ready,
    input  logic                m_valid,
    input  logic                m_ready,
    input  concat_pkg::beat_t   m_data,
    input  logic                m_last,
    input  logic                done,
    output int                  errors,
    output int                  pending
);

    concat_pkg::beat_t  q1 [$];
    concat_pkg::beat_t  q2 [$];
    concat_pkg::beat_t  exp_q [$];
    int                 out_idx = 0;
    logic               done_due = 1'b0;

    // subtract zero point, scale, round, shift by 12, clamp
    function automatic concat_pkg::byte_t requant_ref(input concat_pkg::byte_t x,
                                                      input quant_pkg::zero_t z,
                                                      input quant_pkg::scale_t s);
        int v;
        v = (int'(x) - int'(z)) * int'(s);
        v = (v + 2048) >>> 12;
        if (v < 0)
            return 8'h00;
        if (v > 255)
            return 8'hff;
        return v[7:0];
    endfunction

    function automatic concat_pkg::beat_t requant_beat(input concat_pkg::beat_t b,
                                                       input quant_pkg::zero_t z,
                                                       input quant_pkg::scale_t s);
        concat_pkg::beat_t r;
        for (int i = 0; i < concat_pkg::LANES; i++)
            r[i*8 +: 8] = requant_ref(b[i*8 +: 8], z, s);
        return r;
    endfunction

    // first source's beats, then the second's, for one pixel
    task automatic queue_pixel();
        int n1;
        int n2;
        n1 = int'(first_channels) / concat_pkg::LANES;
        n2 = int'(second_channels) / concat_pkg::LANES;
        if (q1.size() >= n1 && q2.size() >= n2) begin
            for (int i = 0; i < n1; i++)
                exp_q.push_back(requant_beat(q1.pop_front(), first_zero, first_scale));
            for (int i = 0; i < n2; i++)
                exp_q.push_back(requant_beat(q2.pop_front(), second_zero, second_scale));
        end
    endtask

    task automatic check_beat();
        int                 total;
        logic               want_last;
        concat_pkg::beat_t  want;
        total = int'(rows) * int'(cols) *
                ((int'(first_channels) + int'(second_channels)) / concat_pkg::LANES);
        want_last = (out_idx == total - 1);
        if (exp_q.size() == 0)
            queue_pixel();
        if (exp_q.size() == 0) begin
            errors++;
            $display("output beat %0d at %0t came out with no matching input beats",
                     out_idx, $time);
        end else begin
            want = exp_q.pop_front();
            if (m_data !== want) begin
                errors++;
                $display("[FAIL] %0t: beat %0d data %h, expected %h",
                         $time, out_idx, m_data, want);
            end
        end
        if (m_last !== want_last) begin
            errors++;
            $display("[FAIL] %0t: beat %0d m_last %b, expected %b",
                     $time, out_idx, m_last, want_last);
        end
        done_due = want_last;
        out_idx  = want_last ? 0 : out_idx + 1;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            q1.delete();
            q2.delete();
            exp_q.delete();
            out_idx  = 0;
            done_due = 1'b0;
            errors   = 0;
        end else begin
            if (s1_valid && s1_ready)
                q1.push_back(s1_data);
            if (s2_valid && s2_ready)
                q2.push_back(s2_data);
            if (done !== done_due) begin
                errors++;
                $display("[FAIL] %0t: done %b, expected %b", $time, done, done_due);
            end
            done_due = 1'b0;
            if (m_valid && m_ready)
                check_beat();
        end
        pending = q1.size() + q2.size() + exp_q.size();
    end

endmodule

/* tests/tb_concat_top.sv */
`timescale 1ns/1ps

module tb_concat_top;

    // 16 + 24 + 30 + 24 + 9 + 12 output beats over the six frames
    localparam int TOTAL_BEATS = 115;
    localparam int NUM_TESTS   = 5;
    localparam int TIMEOUT     = TOTAL_BEATS * 40 + NUM_TESTS * 200;

    logic                       clk = 1'b0;
    logic                       rst;
    logic                       start;
    concat_pkg::dim_t           rows;
    concat_pkg::dim_t           cols;
    concat_pkg::chan_t          first_channels;
    concat_pkg::chan_t          second_channels;
    quant_pkg::zero_t           first_zero;
    quant_pkg::scale_t          first_scale;
    quant_pkg::zero_t           second_zero;
    quant_pkg::scale_t          second_scale;
    concat_pkg::beat_t          s1_data;
    logic                       s1_valid;
    logic                       s1_ready;
    concat_pkg::beat_t          s2_data;
    logic                       s2_valid;
    logic                       s2_ready;
    logic                       m_valid;
    logic                       m_ready = 1'b0;
    concat_pkg::beat_t          m_data;
    logic                       m_last;
    logic                       done;
    int                         errors;
    int                         pending;

    integer seed = 32'hb3cd9fcb;
    integer s1_seed;
    integer s2_seed;
    integer rdy_seed;
    int     cycles = 0;
    int     gap_pct = 0;
    int     ready_low_pct = 0;
    int     tests_run = 0;
    int     tests_passed = 0;
    int     fail_total = 0;
    bit     watch_full = 1'b0;
    bit     saw_full = 1'b0;

    always #4 clk = ~clk;

    // small input FIFOs so one can be filled
    concat_top #(
        .IN_ADDR_BITS  (4),
        .OUT_ADDR_BITS (6)
    ) i_dut (
        .clk             (clk),
        .rst             (rst),
        .start           (start),
        .rows            (rows),
        .cols            (cols),
        .first_channels  (first_channels),
        .second_channels (second_channels),
        .first_zero      (first_zero),
        .first_scale     (first_scale),
        .second_zero     (second_zero),
        .second_scale    (second_scale),
        .s1_data         (s1_data),
        .s1_valid        (s1_valid),
        .s1_ready        (s1_ready),
        .s2_data         (s2_data),
        .s2_valid        (s2_valid),
        .s2_ready        (s2_ready),
        .m_valid         (m_valid),
        .m_ready         (m_ready),
        .m_data          (m_data),
        .m_last          (m_last),
        .done            (done)
    );

    tb_concat_checker i_check (
        .clk             (clk),
        .rst             (rst),
        .rows            (rows),
        .cols            (cols),
        .first_channels  (first_channels),
        .second_channels (second_channels),
        .first_zero      (first_zero),
        .first_scale     (first_scale),
        .second_zero     (second_zero),
        .second_scale    (second_scale),
        .s1_data         (s1_data),
        .s1_valid        (s1_valid),
        .s1_ready        (s1_ready),
        .s2_data         (s2_data),
        .s2_valid        (s2_valid),
        .s2_ready        (s2_ready),
        .m_valid         (m_valid),
        .m_ready         (m_ready),
        .m_data          (m_data),
        .m_last          (m_last),
        .done            (done),
        .errors          (errors),
        .pending         (pending)
    );

    //////////////////////////////////////////////////////////////////////
    // watchdog and output back-pressure

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("timed out after %0d cycles, a frame never finished", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    always @(negedge clk) begin
        m_ready = ({$random(rdy_seed)} % 100) >= ready_low_pct;
        if (watch_full && !s2_ready)
            saw_full = 1'b1;
    end

    //////////////////////////////////////////////////////////////////////
    // stream drivers

    task automatic send_s1(input int n);
        concat_pkg::beat_t b;
        for (int i = 0; i < n; i++) begin
            while (({$random(s1_seed)} % 100) < gap_pct)
                @(negedge clk);
            for (int k = 0; k < 4; k++)
                b[k*32 +: 32] = $random(s1_seed);
            s1_data  = b;
            s1_valid = 1'b1;
            while (!s1_ready)
                @(negedge clk);
            @(negedge clk);     // taken at the posedge in between
            s1_valid = 1'b0;
        end
    endtask

    task automatic send_s2(input int n);
        concat_pkg::beat_t b;
        for (int i = 0; i < n; i++) begin
            while (({$random(s2_seed)} % 100) < gap_pct)
                @(negedge clk);
            for (int k = 0; k < 4; k++)
                b[k*32 +: 32] = $random(s2_seed);
            s2_data  = b;
            s2_valid = 1'b1;
            while (!s2_ready)
                @(negedge clk);
            @(negedge clk);
            s2_valid = 1'b0;
        end
    endtask

    task automatic run_frame(input int r, input int c, input int ch1, input int ch2,
                             input int z1, input int sc1, input int z2, input int sc2,
                             input bit s2_first);
        int n1;
        int n2;
        n1 = r * c * ch1 / concat_pkg::LANES;
        n2 = r * c * ch2 / concat_pkg::LANES;
        rows            = concat_pkg::dim_t'(r);
        cols            = concat_pkg::dim_t'(c);
        first_channels  = concat_pkg::chan_t'(ch1);
        second_channels = concat_pkg::chan_t'(ch2);
        first_zero      = quant_pkg::zero_t'(z1);
        first_scale     = quant_pkg::scale_t'(sc1);
        second_zero     = quant_pkg::zero_t'(z2);
        second_scale    = quant_pkg::scale_t'(sc2);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (s2_first) begin
            send_s2(n2);
            send_s1(n1);
        end else begin
            fork
                send_s1(n1);
                send_s2(n2);
            join
        end
        while (done !== 1'b1)
            @(negedge clk);
        @(negedge clk);
    endtask

    task automatic report_test(input int id, input string name, input int err_before,
                               input bit extra_ok);
        int n;
        n = errors - err_before;
        if (pending != 0) begin
            $display("test %0d: %0d input or expected beats left over", id, pending);
            n++;
        end
        if (!extra_ok)
            n++;
        tests_run++;
        if (n == 0)
            tests_passed++;
        fail_total += n;
        $display("test %0d %s: %s, %0d errors", id, name, (n == 0) ? "pass" : "fail", n);
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        int err_before;
        rst             = 1'b1;
        start           = 1'b0;
        rows            = '0;
        cols            = '0;
        first_channels  = '0;
        second_channels = '0;
        first_zero      = '0;
        first_scale     = '0;
        second_zero     = '0;
        second_scale    = '0;
        s1_data         = '0;
        s1_valid        = 1'b0;
        s2_data         = '0;
        s2_valid        = 1'b0;
        s1_seed  = seed;
        s2_seed  = seed + 1;
        rdy_seed = seed + 2;

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        err_before = errors;
        run_frame(2, 2, 32, 32, 0, 4096, 0, 4096, 0);
        report_test(1, "identity requant", err_before, 1'b1);

        // zero points and scales wide enough to clamp at both ends
        err_before = errors;
        run_frame(3, 2, 48, 16, 100, 12000, 30, 2500, 0);
        report_test(2, "random requant", err_before, 1'b1);

        err_before = errors;
        ready_low_pct = 60;
        run_frame(2, 3, 32, 48, 12, 5000, 200, 3000, 0);
        ready_low_pct = 0;
        report_test(3, "output back-pressure", err_before, 1'b1);

        // s2 frame is exactly one input FIFO deep
        err_before = errors;
        gap_pct    = 50;
        watch_full = 1'b1;
        run_frame(2, 2, 32, 64, 5, 4096, 60, 6000, 1);
        watch_full = 1'b0;
        gap_pct    = 0;
        if (!saw_full)
            $display("test 4: the s2 input FIFO never filled, s2_ready stayed high");
        report_test(4, "input gaps and full FIFO", err_before, saw_full);

        err_before = errors;
        run_frame(1, 3, 16, 32, 0, 4096, 10, 4500, 0);
        run_frame(3, 1, 48, 16, 90, 3000, 0, 4096, 0);
        report_test(5, "two frames", err_before, 1'b1);

        $display("%0d of %0d tests passed, %0d errors", tests_passed, tests_run, fail_total);
        if (tests_passed == tests_run && fail_total == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* verilog/concat_pkg.sv */
package concat_pkg;

    //////////////////////////////////////////////////////////////////////
    // stream shape

    localparam int LANES = 16;       // bytes per beat

    typedef logic [7:0]         byte_t;
    typedef logic [LANES*8-1:0] beat_t;

    typedef logic [10:0] dim_t;      // rows or cols
    typedef logic [9:0]  chan_t;     // channels of one source

    //////////////////////////////////////////////////////////////////////
    // pixel sequencer

    typedef enum logic [2:0] {
        idle,
        wait_data,
        read_first,
        read_second,
        next_pixel
    } seq_state_t;

endpackage

/* verilog/concat_requant.sv */
`timescale 1ns/1ps

module concat_requant (
    input  logic                clk,
    input  concat_pkg::beat_t   in_data,
    input  logic                in_valid,
    input  quant_pkg::zero_t    zero,
    input  quant_pkg::scale_t   scale,
    output concat_pkg::beat_t   out_data,
    output logic                out_valid
);

    localparam quant_pkg::prod_t ROUND = 1 << (quant_pkg::QUANT_SHIFT - 1);

    quant_pkg::prod_t   prod_d [concat_pkg::LANES];
    quant_pkg::prod_t   prod_q [concat_pkg::LANES];
    concat_pkg::beat_t  beat_d;
    logic               valid_q;

    for (genvar i = 0; i < concat_pkg::LANES; i++) begin : g_lane
        quant_pkg::diff_t   diff;
        quant_pkg::prod_t   shifted;
        concat_pkg::byte_t  lane;

        // stage one: remove zero point, scale
        assign diff      = $signed({1'b0, in_data[i*8 +: 8]}) - $signed({1'b0, zero});
        assign prod_d[i] = diff * $signed({1'b0, scale});

        // stage two: round, shift, clamp to a byte
        assign shifted = (prod_q[i] + ROUND) >>> quant_pkg::QUANT_SHIFT;
        assign lane    = (shifted < 0)   ? 8'h00 :
                         (shifted > 255) ? 8'hff : shifted[7:0];
        assign beat_d[i*8 +: 8] = lane;
    end

    always_ff @(posedge clk) begin
        prod_q   <= prod_d;
        out_data <= beat_d;
    end

    // valid rides along, two beats in flight
    always_ff @(posedge clk) begin
        valid_q   <= in_valid;
        out_valid <= valid_q;
    end

endmodule

/* verilog/concat_sequencer.sv */
`timescale 1ns/1ps

module concat_sequencer #(
    parameter int IN_ADDR_BITS  = 6,
    parameter int OUT_ADDR_BITS = 6
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  concat_pkg::dim_t        rows,
    input  concat_pkg::dim_t        cols,
    input  concat_pkg::chan_t       first_channels,
    input  concat_pkg::chan_t       second_channels,
    input  quant_pkg::zero_t        first_zero,
    input  quant_pkg::scale_t       first_scale,
    input  quant_pkg::zero_t        second_zero,
    input  quant_pkg::scale_t       second_scale,
    input  logic [IN_ADDR_BITS:0]   first_count,
    input  logic [IN_ADDR_BITS:0]   second_count,
    input  concat_pkg::beat_t       first_data,
    input  concat_pkg::beat_t       second_data,
    output logic                    first_rd,
    output logic                    second_rd,
    input  logic [OUT_ADDR_BITS:0]  out_count,
    output concat_pkg::beat_t       out_data,
    output logic                    out_wr
);

    localparam int OUT_DEPTH = 2 ** OUT_ADDR_BITS;

    concat_pkg::seq_state_t state;
    concat_pkg::seq_state_t state_nx;
    concat_pkg::chan_t      first_beats;
    concat_pkg::chan_t      second_beats;
    concat_pkg::chan_t      cur_beats;
    concat_pkg::chan_t      beat_cnt;
    concat_pkg::dim_t       col_cnt;
    concat_pkg::dim_t       row_cnt;
    logic                   have_data;
    logic                   last_beat;
    logic                   last_col;
    logic                   last_pixel;
    concat_pkg::beat_t      rq_data;
    quant_pkg::zero_t       rq_zero;
    quant_pkg::scale_t      rq_scale;

    assign first_beats  = first_channels >> $clog2(concat_pkg::LANES);
    assign second_beats = second_channels >> $clog2(concat_pkg::LANES);

    // one whole pixel in both inputs, room for it plus in-flight beats
    assign have_data = (int'(first_count) >= int'(first_beats)) &&
                       (int'(second_count) >= int'(second_beats)) &&
                       (OUT_DEPTH - int'(out_count) >=
                        int'(first_beats) + int'(second_beats) + quant_pkg::REQUANT_LATENCY);

    assign cur_beats  = (state == concat_pkg::read_first) ? first_beats : second_beats;
    assign last_beat  = (beat_cnt == cur_beats - 1'b1);
    assign last_col   = (col_cnt == cols - 1'b1);
    assign last_pixel = last_col && (row_cnt == rows - 1'b1);

    //////////////////////////////////////////////////////////////////////
    // FSM

    always_ff @(posedge clk) begin
        if (rst)
            state <= concat_pkg::idle;
        else
            state <= state_nx;
    end

    always_comb begin
        state_nx = state;
        case (state)
            concat_pkg::idle:        if (start) state_nx = concat_pkg::wait_data;
            concat_pkg::wait_data:   if (have_data) state_nx = concat_pkg::read_first;
            concat_pkg::read_first:  if (last_beat) state_nx = concat_pkg::read_second;
            concat_pkg::read_second: if (last_beat) state_nx = concat_pkg::next_pixel;
            concat_pkg::next_pixel:
                state_nx = last_pixel ? concat_pkg::idle : concat_pkg::wait_data;
            default:                 state_nx = concat_pkg::idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt <= '0;
        end else if (first_rd || second_rd) begin
            beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
        end else begin
            beat_cnt <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || state == concat_pkg::idle) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (state == concat_pkg::next_pixel) begin
            if (last_col) begin
                col_cnt <= '0;
                row_cnt <= last_pixel ? '0 : row_cnt + 1'b1;
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // reads and requant

    assign first_rd  = (state == concat_pkg::read_first);
    assign second_rd = (state == concat_pkg::read_second);

    // one requantizer, source picked per read cycle
    assign rq_data  = first_rd ? first_data  : second_data;
    assign rq_zero  = first_rd ? first_zero  : second_zero;
    assign rq_scale = first_rd ? first_scale : second_scale;

    concat_requant i_requant (
        .clk       (clk),
        .in_data   (rq_data),
        .in_valid  (first_rd | second_rd),
        .zero      (rq_zero),
        .scale     (rq_scale),
        .out_data  (out_data),
        .out_valid (out_wr)
    );

endmodule

/* verilog/concat_top.sv */
`timescale 1ns/1ps

module concat_top #(
    parameter int IN_ADDR_BITS  = 6,
    parameter int OUT_ADDR_BITS = 6
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  concat_pkg::dim_t    rows,
    input  concat_pkg::dim_t    cols,
    input  concat_pkg::chan_t   first_channels,
    input  concat_pkg::chan_t   second_channels,
    input  quant_pkg::zero_t    first_zero,
    input  quant_pkg::scale_t   first_scale,
    input  quant_pkg::zero_t    second_zero,
    input  quant_pkg::scale_t   second_scale,
    input  concat_pkg::beat_t   s1_data,
    input  logic                s1_valid,
    output logic                s1_ready,
    input  concat_pkg::beat_t   s2_data,
    input  logic                s2_valid,
    output logic                s2_ready,
    output logic                m_valid,
    input  logic                m_ready,
    output concat_pkg::beat_t   m_data,
    output logic                m_last,
    output logic                done
);

    logic                   s1_full;
    logic                   s2_full;
    logic [IN_ADDR_BITS:0]  s1_count;
    logic [IN_ADDR_BITS:0]  s2_count;
    concat_pkg::beat_t      s1_head;
    concat_pkg::beat_t      s2_head;
    logic                   s1_rd;
    logic                   s2_rd;
    logic [OUT_ADDR_BITS:0] out_count;
    concat_pkg::beat_t      out_wdata;
    logic                   out_wr;
    logic                   out_empty;

    assign s1_ready = ~s1_full;
    assign s2_ready = ~s2_full;
    assign m_valid  = ~out_empty;

    //////////////////////////////////////////////////////////////////////
    // input buffers

    stream_fifo #(.ADDR_BITS(IN_ADDR_BITS)) i_s1_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr_data (s1_data),
        .wr_en   (s1_valid & s1_ready),
        .full    (s1_full),
        .rd_data (s1_head),
        .rd_en   (s1_rd),
        .empty   (),
        .count   (s1_count)
    );

    stream_fifo #(.ADDR_BITS(IN_ADDR_BITS)) i_s2_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr_data (s2_data),
        .wr_en   (s2_valid & s2_ready),
        .full    (s2_full),
        .rd_data (s2_head),
        .rd_en   (s2_rd),
        .empty   (),
        .count   (s2_count)
    );

    concat_sequencer #(
        .IN_ADDR_BITS  (IN_ADDR_BITS),
        .OUT_ADDR_BITS (OUT_ADDR_BITS)
    ) i_sequencer (
        .clk             (clk),
        .rst             (rst),
        .start           (start),
        .rows            (rows),
        .cols            (cols),
        .first_channels  (first_channels),
        .second_channels (second_channels),
        .first_zero      (first_zero),
        .first_scale     (first_scale),
        .second_zero     (second_zero),
        .second_scale    (second_scale),
        .first_count     (s1_count),
        .second_count    (s2_count),
        .first_data      (s1_head),
        .second_data     (s2_head),
        .first_rd        (s1_rd),
        .second_rd       (s2_rd),
        .out_count       (out_count),
        .out_data        (out_wdata),
        .out_wr          (out_wr)
    );

    //////////////////////////////////////////////////////////////////////
    // output side

    // sequencer keeps room, so full is never hit
    stream_fifo #(.ADDR_BITS(OUT_ADDR_BITS)) i_out_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr_data (out_wdata),
        .wr_en   (out_wr),
        .full    (),
        .rd_data (m_data),
        .rd_en   (m_ready),     // ignored while empty
        .empty   (out_empty),
        .count   (out_count)
    );

    concat_tracker i_tracker (
        .clk             (clk),
        .rst             (rst),
        .rows            (rows),
        .cols            (cols),
        .first_channels  (first_channels),
        .second_channels (second_channels),
        .m_valid         (m_valid),
        .m_ready         (m_ready),
        .m_last          (m_last),
        .done            (done)
    );

endmodule

/* verilog/concat_tracker.sv */
`timescale 1ns/1ps

module concat_tracker (
    input  logic                clk,
    input  logic                rst,
    input  concat_pkg::dim_t    rows,
    input  concat_pkg::dim_t    cols,
    input  concat_pkg::chan_t   first_channels,
    input  concat_pkg::chan_t   second_channels,
    input  logic                m_valid,
    input  logic                m_ready,
    output logic                m_last,
    output logic                done
);

    concat_pkg::chan_t  pix_beats;
    concat_pkg::chan_t  beat_cnt;
    concat_pkg::dim_t   col_cnt;
    concat_pkg::dim_t   row_cnt;
    logic               accept;
    logic               last_beat;
    logic               last_col;
    logic               last_row;

    assign pix_beats = (first_channels >> $clog2(concat_pkg::LANES)) +
                       (second_channels >> $clog2(concat_pkg::LANES));

    assign accept    = m_valid & m_ready;
    assign last_beat = (beat_cnt == pix_beats - 1'b1);
    assign last_col  = (col_cnt == cols - 1'b1);
    assign last_row  = (row_cnt == rows - 1'b1);

    assign m_last = m_valid && last_beat && last_col && last_row;

    // counters wrap to zero after the final beat
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt <= '0;
            col_cnt  <= '0;
            row_cnt  <= '0;
        end else if (accept) begin
            beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
            if (last_beat) begin
                col_cnt <= last_col ? '0 : col_cnt + 1'b1;
                if (last_col)
                    row_cnt <= last_row ? '0 : row_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            done <= 1'b0;
        else
            done <= m_last & m_ready;   // one cycle after the final accept
    end

endmodule

/* verilog/quant_pkg.sv */
package quant_pkg;

    typedef logic [7:0]  zero_t;
    typedef logic [15:0] scale_t;

    // byte minus zero point, 9 bit signed
    typedef logic signed [8:0]  diff_t;
    // diff times scale, with room for the rounding add
    typedef logic signed [25:0] prod_t;

    localparam int QUANT_SHIFT = 12;

    // requantizer pipeline depth
    localparam int REQUANT_LATENCY = 2;

endpackage

/* verilog/stream_fifo.sv */
`timescale 1ns/1ps

// first-word-fall-through, rd_data shows the head
module stream_fifo #(
    parameter int ADDR_BITS = 6
) (
    input  logic                clk,
    input  logic                rst,
    input  concat_pkg::beat_t   wr_data,
    input  logic                wr_en,
    output logic                full,
    output concat_pkg::beat_t   rd_data,
    input  logic                rd_en,
    output logic                empty,
    output logic [ADDR_BITS:0]  count
);

    localparam int DEPTH = 2 ** ADDR_BITS;

    concat_pkg::beat_t      mem [DEPTH];
    logic [ADDR_BITS-1:0]   wr_ptr;
    logic [ADDR_BITS-1:0]   rd_ptr;
    logic                   do_wr;
    logic                   do_rd;

    assign full  = (count == (ADDR_BITS+1)'(DEPTH));
    assign empty = (count == '0);
    assign do_wr = wr_en & ~full;   // drop writes when full
    assign do_rd = rd_en & ~empty;

    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule
